//--- src/cnn_pkg.sv
package cnn_pkg;

    // Operation code, low byte of command word 0
    typedef logic [7:0] op_t;

    localparam op_t op_conv3x3     = 8'd1;
    localparam op_t op_pool3x3_max = 8'd3;

    // Words per compressed command
    localparam int cmd_burst_len = 5;

    // FIFO words per 3x3 window, high half of the last word is unused
    localparam int win_burst_len = 5;
    localparam int win_elems     = 9;

    // One window element or bias value
    typedef logic signed [15:0] elem_t;

    // Accumulator wide enough for bias plus many channels of products
    typedef logic signed [39:0] acc_t;

    // Decoded command as handed to the loader
    typedef struct packed {
        op_t         op;
        logic [15:0] ich_size;
        logic [15:0] och_size;
        logic [31:0] write_addr;
        // Last command of the job
        logic        is_final;
    } cmd_t;

    // One packed 3x3 window with its position tags
    typedef struct packed {
        elem_t [win_elems-1:0] data;
        elem_t [win_elems-1:0] weight;
        elem_t                 bias;
        op_t                   op;
        logic                  first;
        logic                  last;
        logic [31:0]           addr;
        logic                  job_end;
    } window_t;

endpackage

//--- src/cmd_collector.sv
`timescale 1ns/1ps

module cmd_collector (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          op_en,
    input  logic [31:0]   cmd,
    input  logic          cmd_fifo_empty,
    input  logic          busy,
    output logic          cmd_fifo_rd_en,
    output logic          cmd_valid,
    output cnn_pkg::cmd_t cmd_out
);

    import cnn_pkg::*;

    typedef enum logic [1:0] {
        idle,
        collect,
        hold,
        done
    } state_t;

    state_t      state;
    logic [2:0]  burst_cnt;

    op_t         op_q;
    logic [15:0] ich_q;
    logic [15:0] och_q;
    logic [31:0] waddr_q;

    // Show-ahead FIFO, word is popped in the cycle it is taken
    assign cmd_fifo_rd_en = (state == collect) && !cmd_fifo_empty;

    // Presented for one cycle, loader is known to be idle here
    assign cmd_valid = (state == done);

    // Nothing left behind this command means it closes the job
    assign cmd_out = '{
        op:         op_q,
        ich_size:   ich_q,
        och_size:   och_q,
        write_addr: waddr_q,
        is_final:   cmd_fifo_empty
    };

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            burst_cnt <= 3'(cmd_burst_len);
        end else begin
            case (state)
                idle: begin
                    burst_cnt <= 3'(cmd_burst_len);
                    if (op_en) begin
                        state <= collect;
                    end
                end
                collect: begin
                    if (cmd_fifo_rd_en) begin
                        burst_cnt <= burst_cnt - 3'd1;
                        if (burst_cnt == 3'd1) begin
                            // Loader still working on the previous command
                            state <= busy ? hold : done;
                        end
                    end
                end
                hold: begin
                    if (!busy) begin
                        state <= done;
                    end
                end
                done: begin
                    burst_cnt <= 3'(cmd_burst_len);
                    state     <= cmd_fifo_empty ? idle : collect;
                end
                default: state <= idle;
            endcase
        end
    end

    // Field split, count runs from the first word down to the last
    // Stride and the two start addresses are not used here
    always_ff @(posedge clk) begin
        if (cmd_fifo_rd_en) begin
            case (burst_cnt)
                3'd5: op_q <= op_t'(cmd[7:0]);
                3'd4: begin
                    ich_q <= cmd[15:0];
                    och_q <= cmd[31:16];
                end
                3'd1: waddr_q <= cmd;
                default: ;
            endcase
        end
    end

endmodule

//--- src/operand_loader.sv
`timescale 1ns/1ps

module operand_loader (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_valid,
    input  cnn_pkg::cmd_t    cmd_in,
    input  logic [31:0]      data,
    input  logic             data_fifo_empty,
    input  logic [31:0]      weightbias,
    input  logic             weight_fifo_empty,
    output logic             busy,
    output logic             data_fifo_rd_en,
    output logic             weight_fifo_rd_en,
    output logic             win_valid,
    output cnn_pkg::window_t win
);

    import cnn_pkg::*;

    typedef enum logic [1:0] {
        idle,
        bias,
        load
    } state_t;

    state_t      state;

    // Latched command
    op_t         op_q;
    logic [31:0] addr_q;
    logic        final_q;
    logic [15:0] ich_last;
    logic [15:0] och_last;

    logic [15:0] out_idx;
    logic [15:0] win_idx;
    logic [2:0]  word_cnt;

    logic        is_conv;
    logic        can_pop;
    logic        last_word;
    logic        last_win;
    logic        last_out;

    assign is_conv = (op_q == op_conv3x3);

    // Conv moves data and weights in lock-step, pool needs data only
    assign can_pop = !data_fifo_empty && (!is_conv || !weight_fifo_empty);

    assign data_fifo_rd_en   = (state == load) && can_pop;
    assign weight_fifo_rd_en = ((state == bias) && !weight_fifo_empty) ||
                               ((state == load) && is_conv && can_pop);

    assign last_word = (word_cnt == 3'd1);
    assign last_win  = (win_idx == ich_last);
    assign last_out  = (out_idx == och_last);

    assign busy = (state != idle);

    // A zero size still means one window or one output
    always_ff @(posedge clk) begin
        if (cmd_valid && (state == idle)) begin
            op_q     <= cmd_in.op;
            addr_q   <= cmd_in.write_addr;
            final_q  <= cmd_in.is_final;
            ich_last <= (cmd_in.ich_size == 16'd0) ? 16'd0 : cmd_in.ich_size - 16'd1;
            och_last <= (cmd_in.och_size == 16'd0) ? 16'd0 : cmd_in.och_size - 16'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            out_idx   <= '0;
            win_idx   <= '0;
            word_cnt  <= 3'(win_burst_len);
            win_valid <= 1'b0;
        end else begin
            win_valid <= 1'b0;
            case (state)
                idle: begin
                    if (cmd_valid) begin
                        out_idx  <= '0;
                        win_idx  <= '0;
                        word_cnt <= 3'(win_burst_len);
                        // Other op codes are swallowed here
                        if (cmd_in.op == op_conv3x3) begin
                            state <= bias;
                        end else if (cmd_in.op == op_pool3x3_max) begin
                            state <= load;
                        end
                    end
                end
                bias: begin
                    if (weight_fifo_rd_en) begin
                        state <= load;
                    end
                end
                load: begin
                    if (data_fifo_rd_en) begin
                        word_cnt <= word_cnt - 3'd1;
                        if (last_word) begin
                            win_valid <= 1'b1;
                            word_cnt  <= 3'(win_burst_len);
                            if (!last_win) begin
                                win_idx <= win_idx + 16'd1;
                            end else begin
                                win_idx <= '0;
                                if (last_out) begin
                                    state <= idle;
                                end else begin
                                    // Next output, conv fetches a fresh bias first
                                    out_idx <= out_idx + 16'd1;
                                    state   <= is_conv ? bias : load;
                                end
                            end
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Halfwords enter at the top so element 0 ends up as the first low half
    always_ff @(posedge clk) begin
        if ((state == bias) && weight_fifo_rd_en) begin
            win.bias <= elem_t'(weightbias[15:0]);
        end
        if (data_fifo_rd_en) begin
            if (last_word) begin
                win.data    <= {data[15:0], win.data[win_elems-1:1]};
                win.op      <= op_q;
                win.first   <= (win_idx == 16'd0);
                win.last    <= last_win;
                win.addr    <= addr_q + 32'(out_idx);
                win.job_end <= final_q && last_win && last_out;
            end else begin
                win.data <= {data[31:16], data[15:0], win.data[win_elems-1:2]};
            end
        end
        if ((state == load) && weight_fifo_rd_en) begin
            if (last_word) begin
                win.weight <= {weightbias[15:0], win.weight[win_elems-1:1]};
            end else begin
                win.weight <= {weightbias[31:16], weightbias[15:0],
                               win.weight[win_elems-1:2]};
            end
        end
    end

endmodule

//--- src/window_compute.sv
`timescale 1ns/1ps

module window_compute (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             win_valid,
    input  cnn_pkg::window_t win,
    output logic             wr_en,
    output logic [31:0]      w_addr,
    output logic [15:0]      wr_data,
    output logic             irq
);

    import cnn_pkg::*;

    acc_t  acc;
    acc_t  prod_sum;
    acc_t  total;
    elem_t win_max;
    elem_t run_max;
    elem_t pool_max;
    logic  is_conv;
    logic  is_pool;
    logic  end_q;

    // ReLU then clamp into the positive 16-bit range
    function automatic logic [15:0] relu_sat(acc_t v);
        if (v < 0) begin
            return 16'h0000;
        end else if (v > 40'sh7fff) begin
            return 16'h7fff;
        end
        return v[15:0];
    endfunction

    assign is_conv = (win.op == op_conv3x3);
    assign is_pool = (win.op == op_pool3x3_max);

    // Nine products and the window maximum
    always_comb begin
        prod_sum = '0;
        win_max  = win.data[0];
        for (int i = 0; i < win_elems; i++) begin
            prod_sum = prod_sum + acc_t'(win.data[i]) * acc_t'(win.weight[i]);
            if (win.data[i] > win_max) begin
                win_max = win.data[i];
            end
        end
    end

    // Bias enters once, on the first channel of each output
    assign total = win.first ? (acc_t'(win.bias) + prod_sum) : (acc + prod_sum);

    assign pool_max = (win.first || (win_max > run_max)) ? win_max : run_max;

    always_ff @(posedge clk) begin
        if (win_valid) begin
            acc     <= total;
            run_max <= pool_max;
            if (win.last) begin
                w_addr  <= win.addr;
                wr_data <= is_conv ? relu_sat(total) : pool_max;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
            end_q <= 1'b0;
            irq   <= 1'b0;
        end else begin
            wr_en <= win_valid && win.last && (is_conv || is_pool);
            end_q <= win_valid && win.last && win.job_end;
            // Sticky until reset
            if (wr_en && end_q) begin
                irq <= 1'b1;
            end
        end
    end

endmodule

//--- src/cnn_csb_top.sv
`timescale 1ns/1ps

module cnn_csb_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        op_en,
    input  logic [31:0] cmd,
    input  logic        cmd_fifo_empty,
    output logic        cmd_fifo_rd_en,
    input  logic [31:0] data,
    input  logic        data_fifo_empty,
    output logic        data_fifo_rd_en,
    input  logic [31:0] weightbias,
    input  logic        weight_fifo_empty,
    output logic        weight_fifo_rd_en,
    output logic        wr_en,
    output logic [31:0] w_addr,
    output logic [15:0] wr_data,
    output logic        irq
);

    import cnn_pkg::*;

    cmd_t    cur_cmd;
    logic    cmd_valid;
    logic    loader_busy;
    window_t cur_win;
    logic    win_valid;

    // Fetches the next command while the loader is busy with the current one
    cmd_collector u_collector (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_en          (op_en),
        .cmd            (cmd),
        .cmd_fifo_empty (cmd_fifo_empty),
        .busy           (loader_busy),
        .cmd_fifo_rd_en (cmd_fifo_rd_en),
        .cmd_valid      (cmd_valid),
        .cmd_out        (cur_cmd)
    );

    operand_loader u_loader (
        .clk               (clk),
        .rst_n             (rst_n),
        .cmd_valid         (cmd_valid),
        .cmd_in            (cur_cmd),
        .data              (data),
        .data_fifo_empty   (data_fifo_empty),
        .weightbias        (weightbias),
        .weight_fifo_empty (weight_fifo_empty),
        .busy              (loader_busy),
        .data_fifo_rd_en   (data_fifo_rd_en),
        .weight_fifo_rd_en (weight_fifo_rd_en),
        .win_valid         (win_valid),
        .win               (cur_win)
    );

    // Always ready, no back-pressure toward the loader
    window_compute u_compute (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win       (cur_win),
        .wr_en     (wr_en),
        .w_addr    (w_addr),
        .wr_data   (wr_data),
        .irq       (irq)
    );

endmodule

//--- dv/tb_cnn_csb.sv
`timescale 1ns/1ps

module tb_cnn_csb;

    localparam int timeout_cycles = 5000;
    // Cycles watched after irq for stray writes
    localparam int drain_cycles   = 20;

    logic        clk;
    logic        rst_n;
    logic        op_en;
    logic [31:0] cmd;
    logic        cmd_fifo_empty;
    logic        cmd_fifo_rd_en;
    logic [31:0] data;
    logic        data_fifo_empty;
    logic        data_fifo_rd_en;
    logic [31:0] weightbias;
    logic        weight_fifo_empty;
    logic        weight_fifo_rd_en;
    logic        wr_en;
    logic [31:0] w_addr;
    logic [15:0] wr_data;
    logic        irq;

    logic [31:0] tdata [0:511];
    logic [8:0]  rd_ptr;

    // FIFO contents and expected writes of the running test
    logic [31:0] cmd_q [$];
    logic [31:0] data_q [$];
    logic [31:0] wt_q [$];
    logic [31:0] exp_addr_q [$];
    logic [15:0] exp_data_q [$];

    bit          stall_en;
    int          wt_left;
    int          test_errors;
    int          total_errors;
    int          tests_failed;

    cnn_csb_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .op_en             (op_en),
        .cmd               (cmd),
        .cmd_fifo_empty    (cmd_fifo_empty),
        .cmd_fifo_rd_en    (cmd_fifo_rd_en),
        .data              (data),
        .data_fifo_empty   (data_fifo_empty),
        .data_fifo_rd_en   (data_fifo_rd_en),
        .weightbias        (weightbias),
        .weight_fifo_empty (weight_fifo_empty),
        .weight_fifo_rd_en (weight_fifo_rd_en),
        .wr_en             (wr_en),
        .w_addr            (w_addr),
        .wr_data           (wr_data),
        .irq               (irq)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_word();
        next_word = tdata[rd_ptr];
        rd_ptr    = rd_ptr + 9'd1;
    endfunction

    // One section of the data file per test
    task automatic load_section();
        int          n_cmd;
        int          n_data;
        int          n_wt;
        int          n_exp;
        logic [31:0] word;
        stall_en = (next_word() != 32'd0);
        n_cmd    = next_word();
        n_data   = next_word();
        n_wt     = next_word();
        n_exp    = next_word();
        wt_left  = next_word();
        cmd_q.delete();
        data_q.delete();
        wt_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        repeat (n_cmd) cmd_q.push_back(next_word());
        repeat (n_data) data_q.push_back(next_word());
        repeat (n_wt) wt_q.push_back(next_word());
        repeat (n_exp) begin
            exp_addr_q.push_back(next_word());
            word = next_word();
            exp_data_q.push_back(word[15:0]);
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Show-ahead model, head word visible whenever empty is low
    task automatic drive_fifos();
        cmd_fifo_empty = (cmd_q.size() == 0);
        cmd = 32'h0;
        if (cmd_q.size() > 0) begin
            cmd = cmd_q[0];
        end
        data_fifo_empty = (data_q.size() == 0) || (stall_en && ($urandom % 3 == 0));
        data = 32'h0;
        if (data_q.size() > 0) begin
            data = data_q[0];
        end
        weight_fifo_empty = (wt_q.size() == 0) || (stall_en && ($urandom % 3 == 0));
        weightbias = 32'h0;
        if (wt_q.size() > 0) begin
            weightbias = wt_q[0];
        end
    endtask

    task automatic check_read(input bit rd, input bit empty, input string fifo);
        assert (!(rd && empty)) else begin
            $display("The %s FIFO was read while empty", fifo);
            test_errors++;
        end
    endtask

    task automatic check_write();
        logic [31:0] exp_addr;
        logic [15:0] exp_val;
        assert (!irq) else begin
            $display("Write to address %h arrived after irq", w_addr);
            test_errors++;
        end
        assert (exp_addr_q.size() > 0) else begin
            $display("Unexpected extra write of %h to address %h", wr_data, w_addr);
            test_errors++;
        end
        if (exp_addr_q.size() > 0) begin
            exp_addr = exp_addr_q.pop_front();
            exp_val  = exp_data_q.pop_front();
            assert (w_addr == exp_addr) else begin
                $display("** Error w_addr: got %h, expected %h", w_addr, exp_addr);
                test_errors++;
            end
            assert (wr_data == exp_val) else begin
                $display("** Error wr_data: got %h, expected %h", wr_data, exp_val);
                test_errors++;
            end
        end
    endtask

    task automatic run_job(input string name);
        int cycle;
        int after_irq;
        bit seen_irq;
        bit cmd_rd;
        bit data_rd;
        bit wt_rd;
        test_errors = 0;
        cycle       = 0;
        after_irq   = 0;
        seen_irq    = 1'b0;
        op_en       = 1'b0;
        load_section();
        apply_reset();
        drive_fifos();
        op_en = 1'b1;
        while ((after_irq < drain_cycles) && (cycle < timeout_cycles)) begin
            @(negedge clk);
            cmd_rd  = cmd_fifo_rd_en;
            data_rd = data_fifo_rd_en;
            wt_rd   = weight_fifo_rd_en;
            check_read(cmd_rd, cmd_fifo_empty, "command");
            check_read(data_rd, data_fifo_empty, "data");
            check_read(wt_rd, weight_fifo_empty, "weight");
            if (wr_en) begin
                check_write();
            end
            if (irq && !seen_irq) begin
                assert (exp_addr_q.size() == 0) else begin
                    $display("irq raised with %0d writes still missing", exp_addr_q.size());
                    test_errors++;
                end
                seen_irq = 1'b1;
            end
            if (seen_irq) begin
                after_irq++;
            end
            @(posedge clk);
            #1;
            op_en = 1'b0;
            // The DUT took the head word on this edge
            if (cmd_rd && (cmd_q.size() > 0)) begin
                void'(cmd_q.pop_front());
            end
            if (data_rd && (data_q.size() > 0)) begin
                void'(data_q.pop_front());
            end
            if (wt_rd && (wt_q.size() > 0)) begin
                void'(wt_q.pop_front());
            end
            drive_fifos();
            cycle++;
        end
        if (!seen_irq) begin
            $display("Timed out after %0d cycles waiting for irq", timeout_cycles);
            test_errors++;
        end
        assert (exp_addr_q.size() == 0) else begin
            $display("%0d expected writes never arrived", exp_addr_q.size());
            test_errors++;
        end
        assert ((cmd_q.size() == 0) && (data_q.size() == 0)) else begin
            $display("Command or data words were left unread");
            test_errors++;
        end
        assert (wt_q.size() == wt_left) else begin
            $display("Weight FIFO holds %0d words instead of %0d", wt_q.size(), wt_left);
            test_errors++;
        end
        $display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(61980));
        clk               = 1'b0;
        rst_n             = 1'b0;
        op_en             = 1'b0;
        cmd               = 32'h0;
        cmd_fifo_empty    = 1'b1;
        data              = 32'h0;
        data_fifo_empty   = 1'b1;
        weightbias        = 32'h0;
        weight_fifo_empty = 1'b1;
        total_errors      = 0;
        tests_failed      = 0;
        rd_ptr            = '0;
        $readmemh("dv/cnn_csb_testdata.txt", tdata);
        run_job("single conv output");
        run_job("relu and saturation");
        run_job("channel accumulation");
        run_job("max pool");
        run_job("back-to-back job");
        $display("%0d tests, %0d failed, %0d errors", 5, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- dv/cnn_csb_testdata.txt
// Per test, all hex: stall cmd_words data_words weight_words writes weight_left
// then the command words, data words, weight words and expected "address data" pairs
// Single conv output, bias 5 plus dot product 26, high half of last data word ignored
0 5 5 6 1 0
00000001 00010001 00000000 00000000 00000100
00020001 00040003 00060005 00080007 abcd0009
00000005
00020001 00000001 0002ffff 00010003 0000fffe
00000100 0000001f
// ReLU clamps -109 to zero, the second output saturates
0 5 a c 2 0
00000001 00020001 00000000 00000000 00000200
00010001 00010001 00010001 00010001 00000001
10001000 10001000 10001000 10001000 00001000
0000ff9c
ffffffff ffffffff ffffffff ffffffff 0000ffff
00000001
00100010 00100010 00100010 00100010 00000010
00000200 00000000 00000201 00007fff
// Three channels, two outputs, bias +10 and -10
0 5 1e 20 2 0
00000001 00020003 00000000 00000000 00000300
00010001 00010001 00010001 00010001 00000001
00020002 00020002 00020002 00020002 00000002
00010001 00010001 00010001 00010001 00000001
00030003 00030003 00030003 00030003 00000003
00010001 00010001 00010001 00010001 00000001
00020002 00020002 00020002 00020002 00000002
0000000a
00010001 00010001 00010001 00010001 00000001
00010001 00010001 00010001 00010001 00000001
00030003 00030003 00030003 00030003 00000003
0000fff6
00020002 00020002 00020002 00020002 00000002
ffffffff ffffffff ffffffff ffffffff 0000ffff
00020002 00020002 00020002 00020002 00000002
00000300 00000040 00000301 00000047
// Max pool over two windows, one weight word must stay unread
0 5 a 1 1 1
00000003 00010002 00000000 00000000 00000400
0003fffb 00648000 0007ffff 002a0000 7fffff38
0063fffd fff90078 8ad00008 00060005 7fff0077
deadbeef
00000400 00000078
// Conv, unsupported op 2, pool, with random FIFO stalls
1 f a 6 2 0
00000001 00010001 00000000 00000000 00000500
00000002 00010001 00000000 00000000 00000600
00000003 00010001 00000000 00000000 00000700
00030003 00030003 00030003 00030003 00000003
0003fffb 00648000 0007ffff 002a0000 7fffff38
00000003
00020002 00020002 00020002 00020002 00000002
00000500 00000039 00000700 00000064

//--- sources.f
src/cnn_pkg.sv
src/cmd_collector.sv
src/operand_loader.sv
src/window_compute.sv
src/cnn_csb_top.sv
dv/tb_cnn_csb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CNN front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module tb_cnn_csb; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_cnn_csb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
